// ==== verilog/ppu_pkg.sv ====
package ppu_pkg;

  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_MUL = 2'd2 // code 3 is reserved and runs as an add
  } op_t;

  // the regime value k of an n-bit posit lies in -(n-1) .. n-2
  function automatic int k_size(input int n);
    return $clog2(n) + 1;
  endfunction

  // total exponent k * 2^es + e, with one extra bit so a product still fits
  function automatic int te_size(input int n, input int es);
    return k_size(n) + es + 1;
  endfunction

  // significand width including the hidden one
  function automatic int mant_size(input int n, input int es);
    return n - es - 1;
  endfunction

  // full product width plus a trailing sticky bit
  function automatic int frac_full_size(input int n, input int es);
    return 2 * mant_size(n, es) + 1;
  endfunction

endpackage

// ==== verilog/fir_if.sv ====
`timescale 1ns/1ps

interface fir_if #(
  parameter int N = 16,
  parameter int ES = 1
);

  localparam int TE_W = ppu_pkg::te_size(N, ES);
  localparam int W = ppu_pkg::frac_full_size(N, ES);

  logic sign;
  logic signed [TE_W-1:0] te;
  logic [W-1:0] frac; // msb is the hidden one, lsb carries sticky
  logic zero;

  modport src (
    output sign, te, frac, zero
  );

  modport dst (
    input sign, te, frac, zero
  );

endinterface

// ==== verilog/ppu_special.sv ====
`timescale 1ns/1ps

module ppu_special #(
  parameter int N = 16
) (
  input  logic [N-1:0]    p1,
  input  logic [N-1:0]    p2,
  input  ppu_pkg::op_t    op,
  output logic [N-1:0]    p1_cond,
  output logic [N-1:0]    p2_cond,
  output logic [N:0]      special
);

  localparam logic [N-1:0] NAR = {1'b1, {(N-1){1'b0}}};

  logic is_mul;
  logic flag;
  logic [N-1:0] bypass;

  assign is_mul = (op == ppu_pkg::OP_MUL);

  // a - b runs as a + (-b) so the execute stage only sees add or multiply
  assign p1_cond = p1;
  assign p2_cond = (op == ppu_pkg::OP_SUB) ? -p2 : p2;

  always_comb begin
    flag = 1'b1;
    bypass = '0;
    if (p1 == NAR || p2 == NAR) begin
      bypass = NAR;
    end else if (is_mul && (p1 == '0 || p2 == '0)) begin
      bypass = '0;
    end else if (!is_mul && p1 == '0) begin
      bypass = p2_cond;
    end else if (!is_mul && p2_cond == '0) begin
      bypass = p1;
    end else if (!is_mul && (p1 + p2_cond) == '0) begin
      bypass = '0; // x plus its own negation
    end else begin
      flag = 1'b0;
    end
  end

  assign special = {bypass, flag};

  always_comb begin
    if (!$isunknown({p1, p2, op})) begin
      assert #0 (!$isunknown(special))
        else $error("ppu_special: bypass word is unknown for known operands");
    end
  end

endmodule

// ==== verilog/ppu_decode.sv ====
`timescale 1ns/1ps

module ppu_decode #(
  parameter int N = 16,
  parameter int ES = 1
) (
  input  logic [N-1:0] p,
  fir_if.src           fir
);

  localparam int K_W = ppu_pkg::k_size(N);
  localparam int TE_W = ppu_pkg::te_size(N, ES);
  localparam int M = ppu_pkg::mant_size(N, ES);
  localparam int W = ppu_pkg::frac_full_size(N, ES);

  logic [N-1:0] abs_p;
  logic [N-2:0] r;
  logic rc;
  int run;
  logic done;
  logic signed [K_W-1:0] k;
  logic [N-2:0] rem;
  logic [ES-1:0] expv;
  logic [M-1:0] mant;
  int te_i;

  assign abs_p = p[N-1] ? -p : p;
  assign r = abs_p[N-2:0];
  assign rc = r[N-2]; // regime polarity

  // leading run detector on the regime bits
  always_comb begin
    run = 1;
    done = 1'b0;
    for (int i = N - 3; i >= 0; i--) begin
      if (!done && r[i] == rc) begin
        run = run + 1;
      end else begin
        done = 1'b1;
      end
    end
  end

  assign k = rc ? K_W'(run - 1) : K_W'(-run);

  // drop the regime run and its terminator, shifted-in zeros pad a cut exponent
  assign rem = r << (run + 1);
  assign expv = rem[N-2 -: ES];
  assign mant = {1'b1, rem[N-2-ES -: M-1]};

  assign te_i = (int'(k) <<< ES) + int'(expv);

  assign fir.sign = p[N-1];
  assign fir.te = te_i[TE_W-1:0];
  assign fir.frac = {mant, {(W-M){1'b0}}};
  assign fir.zero = (p == '0);

endmodule

// ==== verilog/ppu_execute.sv ====
`timescale 1ns/1ps

module ppu_execute #(
  parameter int N = 16,
  parameter int ES = 1
) (
  input  ppu_pkg::op_t op,
  fir_if.dst           a,
  fir_if.dst           b,
  fir_if.src           y
);

  localparam int TE_W = ppu_pkg::te_size(N, ES);
  localparam int M = ppu_pkg::mant_size(N, ES);
  localparam int W = ppu_pkg::frac_full_size(N, ES);
  localparam int AW = W + 1; // carry bit on top of the adder

  logic is_mul;
  logic [M-1:0] ma, mb;
  logic [2*M-1:0] prod;
  logic swap;
  logic sign_big, sign_small;
  logic signed [TE_W-1:0] te_big, te_small;
  logic [AW-1:0] ext_big, ext_small, aligned, sum, norm;
  logic sticky;
  int diff;
  int lzc;
  int te_i;

  assign is_mul = (op == ppu_pkg::OP_MUL);
  assign ma = a.frac[W-1 -: M];
  assign mb = b.frac[W-1 -: M];
  assign prod = ma * mb;

  // larger magnitude goes first so the subtract never goes negative
  assign swap = (b.te > a.te) || (b.te == a.te && b.frac > a.frac);

  always_comb begin
    sign_big = swap ? b.sign : a.sign;
    sign_small = swap ? a.sign : b.sign;
    te_big = swap ? b.te : a.te;
    te_small = swap ? a.te : b.te;
    ext_big = {1'b0, (swap ? mb : ma), {(AW-1-M){1'b0}}};
    ext_small = {1'b0, (swap ? ma : mb), {(AW-1-M){1'b0}}};

    diff = int'(te_big) - int'(te_small);
    if (diff > AW) begin
      diff = AW;
    end
    aligned = ext_small >> diff;
    sticky = |(ext_small & ~({AW{1'b1}} << diff));
    aligned[0] = aligned[0] | sticky; // jam lost bits into the lsb

    if (sign_big == sign_small) begin
      sum = ext_big + aligned;
    end else begin
      sum = ext_big - aligned;
    end

    lzc = AW;
    for (int i = 0; i < AW; i++) begin
      if (sum[i]) begin
        lzc = AW - 1 - i;
      end
    end
    norm = sum << lzc;
  end

  always_comb begin
    if (is_mul) begin
      y.sign = a.sign ^ b.sign;
      y.zero = a.zero | b.zero;
      te_i = int'(a.te) + int'(b.te);
      if (prod[2*M-1]) begin
        te_i = te_i + 1; // product landed in [2,4)
        y.frac = {prod, 1'b0};
      end else begin
        y.frac = {prod[2*M-2:0], 2'b00};
      end
    end else begin
      y.sign = sign_big;
      y.zero = (sum == '0);
      te_i = int'(te_big) + 1 - lzc;
      y.frac = {norm[AW-1:2], |norm[1:0]};
    end
    y.te = te_i[TE_W-1:0];
  end

  always_comb begin
    if (!y.zero && !$isunknown({a.frac, b.frac, op})) begin
      assert #0 (y.frac[W-1])
        else $error("ppu_execute: nonzero result is not normalized");
    end
  end

endmodule

// ==== verilog/ppu_result.sv ====
`timescale 1ns/1ps

module ppu_result #(
  parameter int N = 16,
  parameter int ES = 1
) (
  fir_if.dst           f,
  output logic [N-1:0] posit
);

  localparam int W = ppu_pkg::frac_full_size(N, ES);
  localparam int TW = ES + W - 1; // exponent and fraction below the hidden one
  localparam int LW = 2 + TW + N; // room for the longest regime run
  localparam logic [N-2:0] MAXPOS = {(N-1){1'b1}};
  localparam logic [N-2:0] MINPOS = {{(N-2){1'b0}}, 1'b1};

  int k_i;
  logic [ES-1:0] expv;
  logic [LW-1:0] v_ext, body;
  logic [N-2:0] mag, mag_r, mag_f;
  logic guard, sticky, round_up;

  assign k_i = int'(f.te) >>> ES;
  assign expv = f.te[ES-1:0];

  // the first regime bit and its terminator are placed and then the run is
  // widened by shifting
  always_comb begin
    if (k_i >= 0) begin
      v_ext = {2'b10, expv, f.frac[W-2:0], {N{1'b0}}};
      body = $signed(v_ext) >>> k_i;
    end else begin
      v_ext = {2'b01, expv, f.frac[W-2:0], {N{1'b0}}};
      body = v_ext >> (-k_i - 1);
    end
  end

  assign mag = body[LW-1 -: N-1];
  assign guard = body[LW-N];
  assign sticky = |body[LW-N-1:0];
  assign round_up = guard & (mag[0] | sticky); // ties go to even
  assign mag_r = mag + {{(N-2){1'b0}}, round_up};

  // clamp rather than run into NaR or zero
  always_comb begin
    if (k_i > N - 2) begin
      mag_f = MAXPOS;
    end else if (k_i < -(N - 2)) begin
      mag_f = MINPOS;
    end else if (mag_r == '0) begin
      mag_f = MAXPOS; // rounding carried out of maxpos
    end else begin
      mag_f = mag_r;
    end
  end

  always_comb begin
    if (f.zero) begin
      posit = '0;
    end else if (f.sign) begin
      posit = -{1'b0, mag_f};
    end else begin
      posit = {1'b0, mag_f};
    end
  end

endmodule

// ==== verilog/ppu_core.sv ====
`timescale 1ns/1ps

module ppu_core #(
  parameter int N = 16,
  parameter int ES = 1
) (
  input  logic         clk,
  input  logic         rst,
  input  logic [N-1:0] p1,
  input  logic [N-1:0] p2,
  input  ppu_pkg::op_t op,
  input  logic         stall,
  output logic [N-1:0] pout,
  output ppu_pkg::op_t op_out
);

  localparam int TE_W = ppu_pkg::te_size(N, ES);
  localparam int W = ppu_pkg::frac_full_size(N, ES);

  logic [N-1:0] p1_cond, p2_cond, pout_normal;
  logic [N:0] special, s1_special;
  ppu_pkg::op_t s1_op;
  logic s1_sign, s1_zero;
  logic signed [TE_W-1:0] s1_te;
  logic [W-1:0] s1_frac;

  fir_if #(.N(N), .ES(ES)) fir1 ();
  fir_if #(.N(N), .ES(ES)) fir2 ();
  fir_if #(.N(N), .ES(ES)) exec_fir ();
  fir_if #(.N(N), .ES(ES)) res_fir ();

  ppu_special #(.N(N)) special0 (.p1(p1), .p2(p2), .op(op), .p1_cond(p1_cond),
                                 .p2_cond(p2_cond), .special(special));
  ppu_decode #(.N(N), .ES(ES)) decode1 (.p(p1_cond), .fir(fir1));
  ppu_decode #(.N(N), .ES(ES)) decode2 (.p(p2_cond), .fir(fir2));
  ppu_execute #(.N(N), .ES(ES)) execute0 (.op(op), .a(fir1), .b(fir2), .y(exec_fir));

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_special <= {{N{1'b0}}, 1'b1}; // bypass a posit zero out of reset
      s1_op <= ppu_pkg::OP_ADD;
    end else if (!stall) begin
      s1_special <= special;
      s1_op <= op;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst && !stall) begin
      s1_sign <= exec_fir.sign;
      s1_te <= exec_fir.te;
      s1_frac <= exec_fir.frac;
      s1_zero <= exec_fir.zero;
    end
  end

  assign res_fir.sign = s1_sign;
  assign res_fir.te = s1_te;
  assign res_fir.frac = s1_frac;
  assign res_fir.zero = s1_zero;

  ppu_result #(.N(N), .ES(ES)) result0 (.f(res_fir), .posit(pout_normal));

  assign pout = s1_special[0] ? s1_special[N:1] : pout_normal;
  assign op_out = s1_op;

  assert property (@(posedge clk) disable iff (rst)
    $past(stall) && !$past(rst) |->
      $stable(s1_op) && $stable(s1_special) && $stable(pout))
    else $error("ppu_core: stage 1 moved while stalled");

endmodule

// ==== tests/tb_ppu_core.sv ====
`timescale 1ns/1ps

module tb_ppu_core;

  localparam int N = 16;
  localparam int ES = 1;
  localparam int EDGE_LIMIT = 100; // ns allowed between two rising edges
  localparam logic [31:0] SEED = 32'hb747c1e3;

  // posit<16,1> patterns, useed is 4
  localparam logic [N-1:0] P_ZERO = 16'h0000;
  localparam logic [N-1:0] P_NAR = 16'h8000;
  localparam logic [N-1:0] P_ONE = 16'h4000; // 0 10 0 ...
  localparam logic [N-1:0] P_ONE_HALF = 16'h4800; // 1.5, fraction msb set
  localparam logic [N-1:0] P_TWO = 16'h5000; // exponent bit set
  localparam logic [N-1:0] P_THREE = 16'h5800;
  localparam logic [N-1:0] P_HALF = 16'h3000; // regime 01, exponent 1
  localparam logic [N-1:0] P_QUARTER = 16'h2000;
  localparam logic [N-1:0] P_MAXPOS = 16'h7fff;
  localparam logic [N-1:0] P_MINPOS = 16'h0001;

  logic clk;
  logic rst;
  logic [N-1:0] p1;
  logic [N-1:0] p2;
  ppu_pkg::op_t op;
  logic stall;
  logic [N-1:0] pout;
  ppu_pkg::op_t op_out;

  int errors = 0;
  int checks = 0;
  int unsigned edge_count = 0;
  time edge_time = 0;

  ppu_core #(.N(N), .ES(ES)) dut0 (
    .clk(clk), .rst(rst), .p1(p1), .p2(p2), .op(op), .stall(stall),
    .pout(pout), .op_out(op_out)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    edge_count = edge_count + 1;
    edge_time = $time;
  end

  // returns exactly 1 ns after the next rising edge
  task automatic wait_edge();
    int unsigned start;
    int n;
    start = edge_count;
    for (n = 0; n < EDGE_LIMIT && edge_count == start; n++) begin
      #1;
    end
    if (edge_count == start) begin
      $display("timeout: no rising clock edge seen within %0d ns", EDGE_LIMIT);
      $display("test failed");
      $finish;
    end else if ($time < edge_time + 1) begin
      #1;
    end
  endtask

  task automatic check_posit(input string what, input logic [N-1:0] got,
                             input logic [N-1:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_op(input string what, input ppu_pkg::op_t exp);
    checks++;
    assert (op_out === exp) else begin
      errors++;
      $display("FAILED at %0d ns: %s op_out, got %0d, expected %0d", $time, what,
               op_out, exp);
    end
  endtask

  // drive 2 ns after an edge, read the result 1 ns after the following edge
  task automatic run_op(input logic [N-1:0] a, input logic [N-1:0] b,
                        input ppu_pkg::op_t o, output logic [N-1:0] res);
    wait_edge();
    #1;
    p1 = a;
    p2 = b;
    op = o;
    wait_edge();
    res = pout;
    check_op("run_op", o);
  endtask

  function automatic logic [N-1:0] negate(input logic [N-1:0] x);
    return ~x + 16'd1;
  endfunction

  function automatic logic [N-1:0] random_posit();
    logic [31:0] r;
    r = $urandom();
    if (r[N-1:0] == P_NAR) begin
      return P_NAR + 16'd1; // keep clear of NaR
    end
    return r[N-1:0];
  endfunction

  task automatic reset_test();
    check_posit("pout after reset", pout, P_ZERO);
    check_op("after reset", ppu_pkg::OP_ADD);
  endtask

  task automatic known_value_test();
    logic [N-1:0] r;
    run_op(P_ONE, P_ONE, ppu_pkg::OP_ADD, r);
    check_posit("1.0 + 1.0", r, P_TWO);
    run_op(P_ONE_HALF, P_TWO, ppu_pkg::OP_MUL, r);
    check_posit("1.5 * 2.0", r, P_THREE);
    run_op(P_THREE, P_ONE, ppu_pkg::OP_SUB, r);
    check_posit("3.0 - 1.0", r, P_TWO);
    run_op(P_HALF, P_HALF, ppu_pkg::OP_MUL, r);
    check_posit("0.5 * 0.5", r, P_QUARTER);
  endtask

  task automatic special_rule_test();
    logic [N-1:0] x, r;
    ppu_pkg::op_t o;
    for (int i = 0; i < 8; i++) begin
      x = random_posit();
      o = ppu_pkg::op_t'($urandom_range(2, 0));
      run_op(P_NAR, x, o, r);
      check_posit("NaR with x", r, P_NAR);
      run_op(x, P_NAR, o, r);
      check_posit("x with NaR", r, P_NAR);
      run_op(x, P_ZERO, ppu_pkg::OP_MUL, r);
      check_posit("x * 0", r, P_ZERO);
      run_op(P_ZERO, x, ppu_pkg::OP_MUL, r);
      check_posit("0 * x", r, P_ZERO);
      run_op(x, P_ZERO, ppu_pkg::OP_ADD, r);
      check_posit("x + 0", r, x);
      run_op(P_ZERO, x, ppu_pkg::OP_ADD, r);
      check_posit("0 + x", r, x);
      run_op(x, x, ppu_pkg::OP_SUB, r);
      check_posit("x - x", r, P_ZERO);
    end
  endtask

  task automatic symmetry_test();
    logic [N-1:0] a, b, ab, ba, neg_ab;
    for (int i = 0; i < 8; i++) begin
      a = random_posit();
      b = random_posit();
      run_op(a, b, ppu_pkg::OP_ADD, ab);
      run_op(b, a, ppu_pkg::OP_ADD, ba);
      check_posit("b + a against a + b", ba, ab);
      run_op(a, b, ppu_pkg::OP_MUL, ab);
      run_op(b, a, ppu_pkg::OP_MUL, ba);
      check_posit("b * a against a * b", ba, ab);
      run_op(negate(a), b, ppu_pkg::OP_MUL, neg_ab);
      check_posit("(-a) * b against -(a * b)", neg_ab, negate(ab));
    end
  endtask

  task automatic saturation_test();
    logic [N-1:0] r;
    run_op(P_MAXPOS, P_MAXPOS, ppu_pkg::OP_MUL, r);
    check_posit("maxpos * maxpos", r, P_MAXPOS);
    run_op(P_MINPOS, P_MINPOS, ppu_pkg::OP_MUL, r);
    check_posit("minpos * minpos", r, P_MINPOS);
  endtask

  task automatic stall_test();
    logic [N-1:0] r;
    run_op(P_ONE_HALF, P_TWO, ppu_pkg::OP_MUL, r);
    check_posit("result before stall", r, P_THREE);
    #1;
    stall = 1'b1; // new inputs below must be ignored
    p1 = P_ONE;
    p2 = P_ONE;
    op = ppu_pkg::OP_ADD;
    for (int i = 0; i < 4; i++) begin
      wait_edge();
      check_posit("pout held under stall", pout, P_THREE);
      check_op("held under stall", ppu_pkg::OP_MUL);
    end
    #1;
    stall = 1'b0;
    p1 = P_THREE;
    p2 = P_ONE;
    op = ppu_pkg::OP_SUB;
    wait_edge();
    check_posit("first result after stall", pout, P_TWO);
    check_op("first result after stall", ppu_pkg::OP_SUB);
  endtask

  initial begin
    rst = 1'b1;
    stall = 1'b0;
    p1 = P_ONE;
    p2 = P_TWO;
    op = ppu_pkg::OP_MUL;
    void'($urandom(SEED));
    repeat (16) wait_edge();
    #1;
    rst = 1'b0;
    reset_test();
    known_value_test();
    special_rule_test();
    symmetry_test();
    saturation_test();
    stall_test();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
verilog/ppu_pkg.sv
verilog/fir_if.sv
verilog/ppu_special.sv
verilog/ppu_decode.sv
verilog/ppu_execute.sv
verilog/ppu_result.sv
verilog/ppu_core.sv
tests/tb_ppu_core.sv

// ==== Bender.yml ====
package:
  name: ppu_core

sources:
  - verilog/ppu_pkg.sv
  - verilog/fir_if.sv
  - verilog/ppu_special.sv
  - verilog/ppu_decode.sv
  - verilog/ppu_execute.sv
  - verilog/ppu_result.sv
  - verilog/ppu_core.sv
  - target: test
    files:
      - tests/tb_ppu_core.sv
